// ==== forth_proc.f ====
+incdir+rtl
rtl/forth_pkg.sv
rtl/uart_pkg.sv
rtl/data_stack.sv
rtl/forth_core.sv
rtl/uart_tx.sv
rtl/forth_proc.sv
tests/forth_proc_properties.sv
tests/forth_proc_tb.sv

// ==== rtl/boot_rom.svh ====
/*
 * Boot program image
 * Fixed ROM contents of the inner interpreter that loop back to address 0
 */

`ifndef BOOT_ROM_SVH
`define BOOT_ROM_SVH

// One phrase per line with the address of its first cell on the right
localparam cell_t boot_image [rom_depth] = '{
	// Prompt character                                       0
	op_lit, "?", op_emit,
	// 7 - 3 as a digit                                       3
	op_lit, 7, op_lit, 3, op_minus,
	op_lit, "0", op_plus, op_emit,
	// Countdown from 3                                       12
	op_lit, 3,
	// Loop body repeats from 14 until zero                   14
	op_lit, 1, op_minus,
	op_dup, op_zero_equal, op_0branch, 14,
	// Discard the spent counter                              21
	op_drop,
	// Green and red on                                       22
	op_lit, 5, op_io_led,
	// Print -2 with the sign first                           25
	op_lit, 2, op_negate,
	op_dup, op_zero_less_than, op_0branch, 35,
	op_lit, "-", op_emit,
	// Magnitude as a digit                                   35
	op_negate,
	op_lit, "0", op_plus, op_emit,
	// (12 and 10) or 1 as a digit                            40
	op_lit, 12, op_lit, 10, op_and,
	op_lit, 1, op_or,
	op_lit, "0", op_plus, op_emit,
	// Blue only and back to the start                        52
	op_lit, 2, op_io_led,
	op_branch, 0,
	// Unused tail                                            57
	0, 0, 0, 0, 0, 0, 0
};

`endif

// ==== rtl/data_stack.sv ====
/*
 * Circular data stack
 * Top and next-of-stack read combinationally while push, pop and
 * top replacement apply at the following clock edge
 */

`timescale 1ns/1ns

module data_stack
	import forth_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  push,
	input  logic  pop,
	input  logic  wr_en,
	input  cell_t wr_data,
	output cell_t top,
	output cell_t next
);

	cell_t      cells [stack_depth];
	stack_ptr_t ptr;
	stack_ptr_t above;
	stack_ptr_t below;

	// Neighbours of the top wrap at both ends
	assign above = ptr + 1'b1;
	assign below = ptr - 1'b1;

	assign top  = cells[ptr];
	assign next = cells[below];

	// Pointer always names the current top
	always_ff @(posedge clk) begin
		if (!reset) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= above;
		end else if (pop) begin
			ptr <= below;
		end
	end

	// Push writes the new top and pop with write folds a binary result
	always_ff @(posedge clk) begin
		if (push) begin
			cells[above] <= wr_data;
		end else if (wr_en) begin
			cells[pop ? below : ptr] <= wr_data;
		end
	end

endmodule

// ==== rtl/forth_core.sv ====
/*
 * Forth inner interpreter
 * Fetches opcodes and inline operands from the boot ROM, drives the data
 * stack, branches, loads the LED register and sends characters under a
 * single transmit credit
 */

`timescale 1ns/1ns

module forth_core
	import forth_pkg::*;
	import uart_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	output logic  push,
	output logic  pop,
	output logic  wr_en,
	output cell_t wr_data,
	input  cell_t top,
	input  cell_t next,
	output logic  tx_valid,
	output char_t tx_data,
	input  logic  tx_credit,
	output logic  led_g,
	output logic  led_b,
	output logic  led_r
);

	`include "boot_rom.svh"

	rom_addr_t pc;
	rom_addr_t pc_next;
	cell_t     rom_word;
	op_e       opcode;
	op_e       pending_op;
	logic      operand_phase;
	logic      operand_next;
	logic      credit;
	logic      led_load;

	// ROM read with the opcode in the low bits
	assign rom_word = boot_image[pc];
	assign opcode   = op_e'(rom_word[opcode_width-1:0]);

	// Low byte of top goes out on emit
	assign tx_data = top[7:0];

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		push         = 1'b0;
		pop          = 1'b0;
		wr_en        = 1'b0;
		wr_data      = top;
		pc_next      = pc + 1'b1;
		operand_next = 1'b0;
		tx_valid     = 1'b0;
		led_load     = 1'b0;
		if (operand_phase) begin
			// Current word is the operand of the held opcode
			case (pending_op)
				op_lit: begin
					push    = 1'b1;
					wr_data = rom_word;
				end
				op_branch: pc_next = rom_addr_t'(rom_word);
				op_0branch: begin
					// Flag is consumed either way
					pop = 1'b1;
					if (top == '0) begin
						pc_next = rom_addr_t'(rom_word);
					end
				end
				default: ;
			endcase
		end else begin
			case (opcode)
				op_lit, op_branch, op_0branch: operand_next = 1'b1;
				// Binary words fold into next-of-stack
				op_plus: begin
					pop     = 1'b1;
					wr_en   = 1'b1;
					wr_data = next + top;
				end
				op_minus: begin
					pop     = 1'b1;
					wr_en   = 1'b1;
					wr_data = next - top;
				end
				op_and: begin
					pop     = 1'b1;
					wr_en   = 1'b1;
					wr_data = next & top;
				end
				op_or: begin
					pop     = 1'b1;
					wr_en   = 1'b1;
					wr_data = next | top;
				end
				op_dup: push = 1'b1;
				op_drop: pop = 1'b1;
				// Forth true is all ones
				op_zero_equal: begin
					wr_en   = 1'b1;
					wr_data = (top == '0) ? '1 : '0;
				end
				op_zero_less_than: begin
					wr_en   = 1'b1;
					wr_data = {cell_width{top[cell_width-1]}};
				end
				op_negate: begin
					wr_en   = 1'b1;
					wr_data = -top;
				end
				op_io_led: begin
					led_load = 1'b1;
					pop      = 1'b1;
				end
				op_emit: begin
					if (credit) begin
						tx_valid = 1'b1;
						pop      = 1'b1;
					end else begin
						// Hold here until the transmitter hands the credit back
						pc_next = pc;
					end
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc            <= '0;
			operand_phase <= 1'b0;
			pending_op    <= op_lit;
			credit        <= 1'b1;
			led_g         <= 1'b1;
			led_b         <= 1'b1;
			led_r         <= 1'b1;
		end else begin
			pc            <= pc_next;
			operand_phase <= operand_next;
			if (operand_next) begin
				pending_op <= opcode;
			end
			// Spent on send and regained on the credit pulse
			credit <= (credit & ~tx_valid) | tx_credit;
			// LEDs are active low
			if (led_load) begin
				{led_r, led_b, led_g} <= ~top[led_count-1:0];
			end
		end
	end

endmodule

// ==== rtl/forth_pkg.sv ====
/*
 * Forth processor definitions
 * Cell and opcode widths, stack and ROM sizing, and the word set
 * of the inner interpreter
 */

package forth_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path sizing
	////////////////////////////////////////////////////////////////////////////

	// Stack cell and ROM word
	localparam int cell_width = 32;
	typedef logic [cell_width-1:0] cell_t;

	// Opcode sits in the low bits of a ROM word
	localparam int opcode_width = 16;

	// Circular data stack
	localparam int stack_depth = 16;
	typedef logic [$clog2(stack_depth)-1:0] stack_ptr_t;

	// Boot ROM with one cell per address
	localparam int rom_depth = 64;
	localparam int rom_addr_width = $clog2(rom_depth);
	typedef logic [rom_addr_width-1:0] rom_addr_t;

	// Green, blue, red
	localparam int led_count = 3;

	////////////////////////////////////////////////////////////////////////////
	// Word set
	////////////////////////////////////////////////////////////////////////////

	// Any value outside this list runs as a no-op
	typedef enum logic [opcode_width-1:0] {
		op_lit,
		op_plus,
		op_minus,
		op_dup,
		op_drop,
		op_zero_equal,
		op_zero_less_than,
		op_negate,
		op_and,
		op_or,
		op_branch,
		op_0branch,
		op_emit,
		op_io_led
	} op_e;

endpackage

// ==== rtl/forth_proc.sv ====
/*
 * Forth processor top level
 * Inner interpreter, data stack and serial transmitter
 */

`timescale 1ns/1ns

module forth_proc
	import forth_pkg::*;
	import uart_pkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic tx,
	output logic led_g,
	output logic led_b,
	output logic led_r
);

	// Core to stack
	logic  push;
	logic  pop;
	logic  wr_en;
	cell_t wr_data;
	cell_t top;
	cell_t next;

	// Core to transmitter under credit flow
	logic  tx_valid;
	char_t tx_data;
	logic  tx_credit;

	forth_core core (
		.clk(clk), .reset(reset),
		.push(push), .pop(pop), .wr_en(wr_en), .wr_data(wr_data),
		.top(top), .next(next),
		.tx_valid(tx_valid), .tx_data(tx_data), .tx_credit(tx_credit),
		.led_g(led_g), .led_b(led_b), .led_r(led_r)
	);

	data_stack stack (
		.clk(clk), .reset(reset),
		.push(push), .pop(pop), .wr_en(wr_en), .wr_data(wr_data),
		.top(top), .next(next)
	);

	uart_tx transmitter (
		.clk(clk), .reset(reset),
		.tx_valid(tx_valid), .tx_data(tx_data), .tx_credit(tx_credit),
		.tx(tx)
	);

endmodule

// ==== rtl/uart_pkg.sv ====
/*
 * Serial transmit definitions
 * Bit timing and frame layout for the transmit line
 */

package uart_pkg;

	// Clocks per serial bit kept short for simulation
	localparam int bit_clocks = 8;

	// Start bit, eight data bits LSB first, stop bit
	localparam int frame_bits = 10;

	typedef logic [7:0] char_t;

endpackage

// ==== rtl/uart_tx.sv ====
/*
 * Serial transmitter
 * Shifts one start, eight data and one stop bit per accepted byte
 * and then returns the credit to the sender
 */

`timescale 1ns/1ns

module uart_tx
	import uart_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  tx_valid,
	input  char_t tx_data,
	output logic  tx_credit,
	output logic  tx
);

	typedef logic [$clog2(bit_clocks)-1:0] timer_t;
	typedef logic [$clog2(frame_bits)-1:0] index_t;

	logic   busy;
	timer_t bit_timer;
	index_t bit_index;
	// Data bits then the stop bit with the LSB out first
	logic [8:0] shift;

	always_ff @(posedge clk) begin
		if (!reset) begin
			busy      <= 1'b0;
			bit_timer <= '0;
			bit_index <= '0;
			tx_credit <= 1'b0;
			tx        <= 1'b1;
		end else begin
			tx_credit <= 1'b0;
			if (tx_valid) begin
				// Start bit begins on this edge
				busy      <= 1'b1;
				bit_timer <= '0;
				bit_index <= '0;
				shift     <= {1'b1, tx_data};
				tx        <= 1'b0;
			end else if (busy) begin
				if (bit_timer == timer_t'(bit_clocks - 1)) begin
					bit_timer <= '0;
					if (bit_index == index_t'(frame_bits - 1)) begin
						// End of stop bit with the line left high
						busy      <= 1'b0;
						tx_credit <= 1'b1;
					end else begin
						tx        <= shift[0];
						shift     <= shift >> 1;
						bit_index <= bit_index + 1'b1;
					end
				end else begin
					bit_timer <= bit_timer + 1'b1;
				end
			end
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the forth_proc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f forth_proc.f \
	--top-module forth_proc_tb \
	--Mdir obj_dir -o forth_proc_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/forth_proc_sim +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Result: PASSED" sim.log; then
	exit 0
fi
exit 1

// ==== tests/forth_proc_properties.sv ====
/*
 * Forth processor bound checks
 * Idle state after reset, transmit credit rule, stop bits and LED patterns
 */

`timescale 1ns/1ns

module forth_proc_properties
	import uart_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic tx,
	input logic led_g,
	input logic led_b,
	input logic led_r,
	input logic tx_valid,
	input logic tx_credit,
	input logic credit,
	input logic busy
);

	int         failure_count = 0;
	logic       reset_seen = 1'b0;
	logic       char_seen = 1'b0;
	logic [2:0] leds;

	// Active low LEDs as red, blue, green
	assign leds = {led_r, led_b, led_g};

	// Tracks reset done and first character launched
	always @(posedge clk) begin
		if (!reset) begin
			reset_seen <= 1'b1;
			char_seen  <= 1'b0;
		end else if (tx_valid) begin
			char_seen <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Idle state
	////////////////////////////////////////////////////////////////////////////

	// Line high and LEDs off from reset until the first send
	idle_before_first_char: assert property (@(posedge clk)
		reset_seen && !char_seen |-> tx && leds == 3'b111)
	else begin
		failure_count++;
		$error("tx or LEDs active before the first character");
	end

	////////////////////////////////////////////////////////////////////////////
	// Credit flow
	////////////////////////////////////////////////////////////////////////////

	// Send only into an idle transmitter
	send_only_when_idle: assert property (@(posedge clk)
		tx_valid |-> !busy)
	else begin
		failure_count++;
		$error("tx_valid during a frame");
	end

	// Credit stays with the transmitter for the whole frame
	no_credit_while_busy: assert property (@(posedge clk)
		busy |-> !credit)
	else begin
		failure_count++;
		$error("core holds a credit while a frame is in progress");
	end

	// Credit comes back only after a full high stop bit
	credit_after_stop_bit: assert property (@(posedge clk)
		tx_credit |-> tx && $past(tx, bit_clocks))
	else begin
		failure_count++;
		$error("credit returned without a high stop bit");
	end

	////////////////////////////////////////////////////////////////////////////
	// LEDs
	////////////////////////////////////////////////////////////////////////////

	// Only the two programmed patterns ever appear
	led_patterns: assert property (@(posedge clk)
		reset_seen && reset && $changed(leds) |-> leds inside {3'b010, 3'b101})
	else begin
		failure_count++;
		$error("LEDs changed to a pattern the program never writes");
	end

endmodule

bind forth_proc forth_proc_properties props (
	.clk(clk), .reset(reset), .tx(tx),
	.led_g(led_g), .led_b(led_b), .led_r(led_r),
	.tx_valid(tx_valid), .tx_credit(tx_credit),
	.credit(core.credit), .busy(transmitter.busy)
);

// ==== tests/forth_proc_tb.sv ====
/*
 * Forth processor testbench
 * Decodes the serial line and checks characters, frame spacing and
 * LED patterns against the boot program's output
 */

`timescale 1ns/1ns

module forth_proc_tb
	import uart_pkg::*;
();

	////////////////////////////////////////////////////////////////////////////
	// Expected output
	////////////////////////////////////////////////////////////////////////////

	// Two passes of the program plus the next prompt
	localparam int stream_length = 11;
	localparam logic [8*stream_length-1:0] expected_stream = "?4-29?4-29?";

	// Active low LEDs as red, blue, green
	localparam logic [2:0] leds_off        = 3'b111;
	// Green and red lit after the LED word with 5
	localparam logic [2:0] leds_after_five = 3'b010;
	// Only blue lit after the LED word with 2
	localparam logic [2:0] leds_after_two  = 3'b101;

	localparam int frame_clocks  = frame_bits * bit_clocks;
	localparam int start_timeout = 300;

	logic clk;
	logic reset;
	logic tx;
	logic led_g;
	logic led_b;
	logic led_r;

	int cycle_count = 0;
	int mismatch_count = 0;
	int timeout_count = 0;

	forth_proc dut (
		.clk(clk), .reset(reset), .tx(tx),
		.led_g(led_g), .led_b(led_b), .led_r(led_r)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	function automatic char_t expected_char(input int index);
		return expected_stream[8*(stream_length-1-index) +: 8];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: %s got %0h expected %0h",
				$time, name, got, expected);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Serial decoder
	////////////////////////////////////////////////////////////////////////////

	// High to low on the line as seen on falling clock edges
	task automatic wait_for_start(output bit found);
		int   waited;
		logic prev;
		found  = 1'b0;
		waited = 0;
		prev   = tx;
		while (!found && waited < start_timeout) begin
			@(negedge clk);
			waited++;
			if (prev === 1'b1 && tx === 1'b0) begin
				found = 1'b1;
			end
			prev = tx;
		end
	endtask

	// Starts in the first cycle of the start bit and samples mid-bit
	task automatic receive_char(output char_t value);
		repeat (bit_clocks / 2) @(negedge clk);
		compare_value("tx start bit", tx, 1'b0);
		for (int b = 0; b < 8; b++) begin
			repeat (bit_clocks) @(negedge clk);
			value[b] = tx;
		end
		repeat (bit_clocks) @(negedge clk);
		compare_value("tx stop bit", tx, 1'b1);
	endtask

	// LEDs at the end of a character where the program fixes them
	task automatic verify_led_pattern(input int index);
		if (index == 0) begin
			compare_value("leds {r,b,g}", {led_r, led_b, led_g}, leds_off);
		end else if (expected_char(index) == "-") begin
			compare_value("leds {r,b,g}", {led_r, led_b, led_g}, leds_after_five);
		end else if (expected_char(index) == "?") begin
			compare_value("leds {r,b,g}", {led_r, led_b, led_g}, leds_after_two);
		end
	endtask

	// Next frame may start only after the credit came back
	task automatic assert_frame_gap(input int gap);
		assert (gap > frame_clocks) else begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: frame gap got %0d expected more than %0d",
				$time, gap, frame_clocks);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		bit    found;
		char_t received;
		int    last_start;
		int    total;
		reset      = 1'b0;
		last_start = -1;
		repeat (8) @(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < stream_length; i++) begin
			wait_for_start(found);
			if (!found) begin
				timeout_count++;
				$display("Timeout at %0t ns: no start bit for character %0d within %0d cycles",
					$time, i, start_timeout);
				break;
			end
			if (last_start >= 0) begin
				assert_frame_gap(cycle_count - last_start);
			end
			last_start = cycle_count;
			receive_char(received);
			compare_value("tx character", received, expected_char(i));
			verify_led_pattern(i);
		end
		total = mismatch_count + timeout_count + dut.props.failure_count;
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, dut.props.failure_count);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
